/* vlog.f */
hdl/lsu_mon_pkg.sv
hdl/lsu_acc_classifier.sv
hdl/lsu_acc_counters.sv
hdl/trvk_order_checker.sv
hdl/lsu_mon_top.sv
verif/lsu_mon_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load/store monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=lsu_mon_sim

verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module lsu_mon_tb \
  --Mdir "$OBJ_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  echo "run passed"
  exit 0
else
  echo "run failed, see $LOG"
  exit 1
fi

/* verif/lsu_mon_tb.sv */
//////////////////////////////////////////////////
// load/store monitor testbench
// table-driven access checks, class counters and
// reservation order tests
//////////////////////////////////////////////////

module lsu_mon_tb import lsu_mon_pkg::*; ();

  localparam int ClkPeriod     = 20;
  localparam int RstCycles     = 16;
  localparam int NumEntries    = 16;
  // access table plus the order tests and their resets
  localparam int TimeoutCycles = NumEntries * 20 + 300;

  typedef struct packed {
    lsu_acc_t     acc;
    lsu_acc_res_t exp;
  } acc_vec_t;

  logic                clk_i;
  logic                rst_ni;
  logic                acc_req_i;
  lsu_acc_t            acc_i;
  logic                acc_ack_o;
  lsu_acc_res_t        res_o;
  lsu_acc_e            cnt_sel_i;
  logic [CntW-1:0]     cnt_o;
  logic                trsv_en_i;
  logic [RegAddrW-1:0] trsv_addr_i;
  logic                trvk_en_i;
  logic [RegAddrW-1:0] trvk_addr_i;
  logic                trvk_err_o;
  logic [PendW-1:0]    pending_o;

  acc_vec_t            vec_tbl [NumEntries];
  logic [CntW-1:0]     tally [NumAccClass];
  logic [RegAddrW-1:0] model_q [$];
  logic                model_err;
  int                  errors;
  int                  checks;
  int                  tests_run;
  int                  tests_failed;
  int                  test_err_base;

  lsu_mon_top lsu_mon_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_req_i   (acc_req_i),
    .acc_i       (acc_i),
    .acc_ack_o   (acc_ack_o),
    .res_o       (res_o),
    .cnt_sel_i   (cnt_sel_i),
    .cnt_o       (cnt_o),
    .trsv_en_i   (trsv_en_i),
    .trsv_addr_i (trsv_addr_i),
    .trvk_en_i   (trvk_en_i),
    .trvk_addr_i (trvk_addr_i),
    .trvk_err_o  (trvk_err_o),
    .pending_o   (pending_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_res(input lsu_acc_res_t got, input lsu_acc_res_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s res %s/%0d/%s, expected %s/%0d/%s", $time, msg,
               got.acc_class.name(), got.xfer_size, got.room_chk.name(),
               exp.acc_class.name(), exp.xfer_size, exp.room_chk.name());
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s ack %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_cnt(input logic [CntW-1:0] got, input logic [CntW-1:0] exp,
                           input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s count %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_err(input logic got_err, input logic exp_err,
                           input logic [PendW-1:0] got_pend, input logic [PendW-1:0] exp_pend,
                           input string msg);
    checks++;
    if (got_err !== exp_err || got_pend !== exp_pend) begin
      errors++;
      $display("Mismatch at %0t: %s err %b pending %0d, expected err %b pending %0d",
               $time, msg, got_err, got_pend, exp_err, exp_pend);
    end
  endtask

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
    end
    $display("test %-18s %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic set_vec(input int idx, input logic is_cap, input logic we, input lsu_type_e t,
                         input logic [AddrW-1:0] addr, input logic [CapTopW-1:0] top,
                         input lsu_acc_e cls, input logic [XferW-1:0] size,
                         input room_chk_e room);
    vec_tbl[idx].acc.is_cap   = is_cap;
    vec_tbl[idx].acc.we       = we;
    vec_tbl[idx].acc.lsu_type = t;
    vec_tbl[idx].acc.addr     = addr;
    vec_tbl[idx].acc.cap_top  = top;
    vec_tbl[idx].exp.acc_class = cls;
    vec_tbl[idx].exp.xfer_size = size;
    vec_tbl[idx].exp.room_chk  = room;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (RstCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    model_q.delete();
    model_err = 1'b0;
  endtask

  // one access over the four-phase handshake with random hold and gap
  task automatic run_access(input int idx);
    int gap;
    int hold;
    string tag;
    gap  = int'($urandom % 4);
    hold = int'($urandom % 4);
    tag  = $sformatf("access %0d", idx);
    repeat (gap) begin
      @(posedge clk_i);
      #2;
    end
    acc_i     = vec_tbl[idx].acc;
    acc_req_i = 1'b1;
    check_ack(acc_ack_o, 1'b0, tag);
    @(posedge clk_i);
    #2;
    check_ack(acc_ack_o, 1'b1, tag);
    check_res(res_o, vec_tbl[idx].exp, tag);
    repeat (hold) begin
      @(posedge clk_i);
      #2;
      check_ack(acc_ack_o, 1'b1, tag);
      check_res(res_o, vec_tbl[idx].exp, tag);
    end
    acc_req_i = 1'b0;
    acc_i     = '0;
    @(posedge clk_i);
    #2;
    check_ack(acc_ack_o, 1'b0, tag);
  endtask

  // reservation is pushed before the revocation is checked
  task automatic order_step(input logic rsv, input logic [RegAddrW-1:0] rsv_addr,
                            input logic rvk, input logic [RegAddrW-1:0] rvk_addr);
    logic [RegAddrW-1:0] head;
    if (rsv) begin
      if (model_q.size() == int'(TrsvDepth) && !rvk) begin
        model_err = 1'b1;
      end else begin
        model_q.push_back(rsv_addr);
      end
    end
    if (rvk) begin
      if (model_q.size() == 0) begin
        model_err = 1'b1;
      end else begin
        head = model_q.pop_front();
        if (head != rvk_addr) begin
          model_err = 1'b1;
        end
      end
    end
    trsv_en_i   = rsv;
    trsv_addr_i = rsv_addr;
    trvk_en_i   = rvk;
    trvk_addr_i = rvk_addr;
    @(posedge clk_i);
    #2;
    trsv_en_i = 1'b0;
    trvk_en_i = 1'b0;
    check_err(trvk_err_o, model_err, pending_o, PendW'(model_q.size()),
              $sformatf("order rsv %b/%0d rvk %b/%0d", rsv, rsv_addr, rvk, rvk_addr));
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    lsu_acc_res_t rst_res;
    void'($urandom(32'h6e8b));
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    rst_ni        = 1'b0;
    acc_req_i     = 1'b0;
    acc_i         = '0;
    cnt_sel_i     = ACC_NULL;
    trsv_en_i     = 1'b0;
    trsv_addr_i   = '0;
    trvk_en_i     = 1'b0;
    trvk_addr_i   = '0;
    model_err     = 1'b0;

    set_vec(0,  1, 0, LSU_WORD, 32'h0000_1000, 33'h0_0000_2000, CAP_RD, 4'd8, ROOM_OVER);
    set_vec(1,  1, 1, LSU_WORD, 32'h0000_1000, 33'h0_0000_1008, CAP_WR, 4'd8, ROOM_EXACT);
    set_vec(2,  1, 0, LSU_HALF, 32'h0000_1000, 33'h0_0000_1004, CAP_RD, 4'd8, ROOM_SHORT);
    set_vec(3,  0, 0, LSU_BYTE, 32'h0000_0003, 33'h0_0000_0004, BYTE_RD, 4'd1, ROOM_EXACT);
    set_vec(4,  0, 1, LSU_BYTE, 32'h0000_0010, 33'h0_0000_0100, BYTE_WR, 4'd1, ROOM_OVER);
    set_vec(5,  0, 0, LSU_HALF, 32'h0000_0020, 33'h0_0000_0022, HW_RD_ALIGNED, 4'd2, ROOM_EXACT);
    set_vec(6,  0, 0, LSU_HALF, 32'h0000_0021, 33'h0_0000_0022, HW_RD_UNALIGNED, 4'd2,
            ROOM_SHORT);
    set_vec(7,  0, 1, LSU_HALF, 32'h0000_0040, 33'h0_0000_0080, HW_WR_ALIGNED, 4'd2, ROOM_OVER);
    set_vec(8,  0, 1, LSU_HALF, 32'h0000_0043, 33'h0_0000_0080, HW_WR_UNALIGNED, 4'd2,
            ROOM_OVER);
    set_vec(9,  0, 0, LSU_WORD, 32'hffff_fffc, 33'h1_0000_0000, WORD_RD_ALIGNED, 4'd4,
            ROOM_EXACT);
    // address past the top
    set_vec(10, 0, 0, LSU_WORD, 32'h0000_0102, 33'h0_0000_0100, WORD_RD_UNALIGNED, 4'd4,
            ROOM_SHORT);
    set_vec(11, 0, 1, LSU_WORD, 32'h0000_0200, 33'h1_0000_0000, WORD_WR_ALIGNED, 4'd4,
            ROOM_OVER);
    set_vec(12, 0, 1, LSU_WORD, 32'h0000_0201, 33'h0_0000_0204, WORD_WR_UNALIGNED, 4'd4,
            ROOM_SHORT);
    set_vec(13, 1, 1, LSU_BYTE, 32'hffff_fff8, 33'h1_0000_0000, CAP_WR, 4'd8, ROOM_EXACT);
    set_vec(14, 0, 0, LSU_WORD, 32'h0000_0003, 33'h0_0000_0008, WORD_RD_UNALIGNED, 4'd4,
            ROOM_OVER);
    set_vec(15, 0, 0, LSU_BYTE, 32'h0000_0000, 33'h0_0000_0000, BYTE_RD, 4'd1, ROOM_SHORT);

    for (int c = 0; c < NumAccClass; c++) begin
      tally[c] = '0;
    end
    for (int i = 0; i < NumEntries; i++) begin
      tally[vec_tbl[i].exp.acc_class] = tally[vec_tbl[i].exp.acc_class] + CntW'(1);
    end

    repeat (RstCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // all-zero access is an aligned word read with no room
    rst_res.acc_class = WORD_RD_ALIGNED;
    rst_res.xfer_size = 4'd4;
    rst_res.room_chk  = ROOM_SHORT;
    check_res(res_o, rst_res, "after reset");
    check_ack(acc_ack_o, 1'b0, "after reset");
    check_err(trvk_err_o, 1'b0, pending_o, '0, "after reset");
    for (int i = 0; i < NumEntries; i++) begin
      run_access(i);
    end
    end_test("access_table");

    for (int c = 0; c < NumAccClass; c++) begin
      cnt_sel_i = lsu_acc_e'(c);
      @(posedge clk_i);
      #2;
      check_cnt(cnt_o, tally[c], $sformatf("class %s", cnt_sel_i.name()));
    end
    end_test("class_counters");

    order_step(1, 5'd3, 0, 5'd0);
    order_step(1, 5'd7, 0, 5'd0);
    order_step(0, 5'd0, 1, 5'd3);
    order_step(1, 5'd9, 1, 5'd7);
    order_step(0, 5'd0, 1, 5'd9);
    order_step(1, 5'd12, 1, 5'd12);
    for (int a = 1; a <= 4; a++) begin
      order_step(1, RegAddrW'(a), 0, 5'd0);
    end
    // full queue relieved by a revocation on the same edge
    order_step(1, 5'd5, 1, 5'd1);
    for (int a = 2; a <= 5; a++) begin
      order_step(0, 5'd0, 1, RegAddrW'(a));
    end
    end_test("order_in_sequence");

    apply_reset();
    order_step(1, 5'd4, 0, 5'd0);
    order_step(1, 5'd6, 0, 5'd0);
    order_step(0, 5'd0, 1, 5'd6);
    repeat (3) order_step(0, 5'd0, 0, 5'd0);
    end_test("order_mismatch");

    apply_reset();
    order_step(0, 5'd0, 1, 5'd2);
    repeat (3) order_step(0, 5'd0, 0, 5'd0);
    end_test("order_underflow");

    apply_reset();
    for (int a = 1; a <= 5; a++) begin
      order_step(1, RegAddrW'(a), 0, 5'd0);
    end
    repeat (3) order_step(0, 5'd0, 0, 5'd0);
    end_test("order_overflow");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* hdl/lsu_mon_top.sv */
//////////////////////////////////////////////////
// load/store monitor top
// req/ack access port, class counters and the
// reservation order checker
//////////////////////////////////////////////////

module lsu_mon_top import lsu_mon_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  // access port, four-phase req/ack
  input  logic                acc_req_i,
  input  lsu_acc_t            acc_i,
  output logic                acc_ack_o,
  output lsu_acc_res_t        res_o,

  // counter read back
  input  lsu_acc_e            cnt_sel_i,
  output logic [CntW-1:0]     cnt_o,

  // reservation / revocation strobes
  input  logic                trsv_en_i,
  input  logic [RegAddrW-1:0] trsv_addr_i,
  input  logic                trvk_en_i,
  input  logic [RegAddrW-1:0] trvk_addr_i,
  output logic                trvk_err_o,
  output logic [PendW-1:0]    pending_o
);

  lsu_acc_res_t cls_res;
  lsu_acc_res_t res_q;
  logic         accept;
  logic         acc_ack_q;

  lsu_acc_classifier lsu_acc_classifier_inst (
    .acc_i (acc_i),
    .res_o (cls_res)
  );

  //////////////////////////////////////////////////
  // handshake and result register
  //////////////////////////////////////////////////

  // new request only once the previous ack has dropped
  assign accept = acc_req_i & ~acc_ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_ack_q <= 1'b0;
      res_q     <= AccResRst;
    end else begin
      if (accept) begin
        acc_ack_q <= 1'b1;
        res_q     <= cls_res;
      end else if (!acc_req_i) begin
        acc_ack_q <= 1'b0;
      end
    end
  end

  assign acc_ack_o = acc_ack_q;
  assign res_o     = res_q;

  //////////////////////////////////////////////////
  // statistics and order check
  //////////////////////////////////////////////////

  // counts on the accept edge, together with the result register
  lsu_acc_counters lsu_acc_counters_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inc_i       (accept),
    .inc_class_i (cls_res.acc_class),
    .cnt_sel_i   (cnt_sel_i),
    .cnt_o       (cnt_o)
  );

  trvk_order_checker trvk_order_checker_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .trsv_en_i   (trsv_en_i),
    .trsv_addr_i (trsv_addr_i),
    .trvk_en_i   (trvk_en_i),
    .trvk_addr_i (trvk_addr_i),
    .trvk_err_o  (trvk_err_o),
    .pending_o   (pending_o)
  );

endmodule

/* hdl/trvk_order_checker.sv */
//////////////////////////////////////////////////
// tag reservation / revocation order checker
// revocations must match reservations in order
//////////////////////////////////////////////////

module trvk_order_checker import lsu_mon_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                trsv_en_i,
  input  logic [RegAddrW-1:0] trsv_addr_i,
  input  logic                trvk_en_i,
  input  logic [RegAddrW-1:0] trvk_addr_i,

  output logic                trvk_err_o,
  output logic [PendW-1:0]    pending_o
);

  logic [RegAddrW-1:0] queue_q [TrsvDepth];
  logic [TrsvPtrW-1:0] wr_ptr_q;
  logic [TrsvPtrW-1:0] rd_ptr_q;
  logic [PendW-1:0]    count_q;
  logic [PendW-1:0]    count_d;
  logic                err_q;

  logic                q_empty;
  logic                q_full;
  logic [RegAddrW-1:0] head_addr;
  logic                push;
  logic                pop;
  logic                underflow;
  logic                mismatch;
  logic                overflow;

  assign q_empty = (count_q == '0);
  assign q_full  = (count_q == PendW'(TrsvDepth));

  //////////////////////////////////////////////////
  // push before pop within one edge
  //////////////////////////////////////////////////

  // on an empty queue the same-edge reservation is the head
  assign head_addr = q_empty ? trsv_addr_i : queue_q[rd_ptr_q];

  assign underflow = trvk_en_i & q_empty & ~trsv_en_i;
  assign mismatch  = trvk_en_i & ~underflow & (head_addr != trvk_addr_i);
  assign overflow  = trsv_en_i & q_full & ~trvk_en_i;

  // a full queue still takes a push when the head leaves on the same edge
  assign push = trsv_en_i & ~overflow;
  assign pop  = trvk_en_i & ~underflow;

  assign count_d = count_q + {{(PendW - 1){1'b0}}, push} - {{(PendW - 1){1'b0}}, pop};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      err_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // sticky until reset
      if (underflow | mismatch | overflow) begin
        err_q <= 1'b1;
      end
    end
  end

  // when full the write slot is the head being popped, which was compared above
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= trsv_addr_i;
    end
  end

  assign trvk_err_o = err_q;
  assign pending_o  = count_q;

endmodule

/* hdl/lsu_acc_counters.sv */
//////////////////////////////////////////////////
// access class counters
// one saturating counter per class, read back by
// class select
//////////////////////////////////////////////////

module lsu_acc_counters import lsu_mon_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            inc_i,
  input  lsu_acc_e        inc_class_i,

  input  lsu_acc_e        cnt_sel_i,
  output logic [CntW-1:0] cnt_o
);

  logic [CntW-1:0]        cnt_q [NumAccClass];
  logic [NumAccClass-1:0] cnt_en;

  //////////////////////////////////////////////////
  // counter array
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumAccClass; i++) begin : g_cnt

    // a full counter holds
    assign cnt_en[i] = inc_i &&
                       (inc_class_i == lsu_acc_e'(i)) &&
                       (cnt_q[i] != {CntW{1'b1}});

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (cnt_en[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end

  end

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  // selects past the last class read as zero
  always_comb begin
    cnt_o = '0;
    if (int'(cnt_sel_i) < NumAccClass) begin
      cnt_o = cnt_q[cnt_sel_i];
    end
  end

endmodule

/* hdl/lsu_acc_classifier.sv */
//////////////////////////////////////////////////
// access classifier
// sorts one load/store access into its class and
// checks the capability room against its size
//////////////////////////////////////////////////

module lsu_acc_classifier import lsu_mon_pkg::*; (
  input  lsu_acc_t     acc_i,
  output lsu_acc_res_t res_o
);

  logic              word_aligned;
  logic              half_aligned;
  lsu_acc_e          acc_class;
  logic [XferW-1:0]  xfer_size;
  // one bit wider than cap_top to catch addr above top
  logic [CapTopW:0]  room;
  logic [CapTopW:0]  xfer_ext;
  room_chk_e         room_chk;

  assign word_aligned = (acc_i.addr[1:0] == 2'b00);
  assign half_aligned = (acc_i.addr[0] == 1'b0);

  //////////////////////////////////////////////////
  // class select
  //////////////////////////////////////////////////

  // capability accesses win over the width field
  always_comb begin
    if (acc_i.is_cap) begin
      acc_class = acc_i.we ? CAP_WR : CAP_RD;
    end else begin
      case (acc_i.lsu_type)
        LSU_WORD: begin
          if (acc_i.we) begin
            acc_class = word_aligned ? WORD_WR_ALIGNED : WORD_WR_UNALIGNED;
          end else begin
            acc_class = word_aligned ? WORD_RD_ALIGNED : WORD_RD_UNALIGNED;
          end
        end
        LSU_HALF: begin
          if (acc_i.we) begin
            acc_class = half_aligned ? HW_WR_ALIGNED : HW_WR_UNALIGNED;
          end else begin
            acc_class = half_aligned ? HW_RD_ALIGNED : HW_RD_UNALIGNED;
          end
        end
        // byte and the unused encoding
        default: begin
          acc_class = acc_i.we ? BYTE_WR : BYTE_RD;
        end
      endcase
    end
  end

  always_comb begin
    if (acc_i.is_cap) begin
      xfer_size = XferCapB;
    end else begin
      case (acc_i.lsu_type)
        LSU_WORD: xfer_size = XferWordB;
        LSU_HALF: xfer_size = XferHalfB;
        default:  xfer_size = XferByteB;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // room check
  //////////////////////////////////////////////////

  assign room     = {1'b0, acc_i.cap_top} - {{(CapTopW - AddrW + 1){1'b0}}, acc_i.addr};
  assign xfer_ext = {{(CapTopW - XferW + 1){1'b0}}, xfer_size};

  // a borrow out means the address sits past the top
  always_comb begin
    if (room[CapTopW]) begin
      room_chk = ROOM_SHORT;
    end else if (room > xfer_ext) begin
      room_chk = ROOM_OVER;
    end else if (room == xfer_ext) begin
      room_chk = ROOM_EXACT;
    end else begin
      room_chk = ROOM_SHORT;
    end
  end

  assign res_o.acc_class = acc_class;
  assign res_o.xfer_size = xfer_size;
  assign res_o.room_chk  = room_chk;

endmodule

/* hdl/lsu_mon_pkg.sv */
//////////////////////////////////////////////////
// lsu monitor package
// widths, access classes and result types shared
// by the load/store monitor blocks
//////////////////////////////////////////////////

package lsu_mon_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  localparam int unsigned AddrW     = 32;
  // one extra bit so a top at 2^32 fits
  localparam int unsigned CapTopW   = 33;
  localparam int unsigned RegAddrW  = 5;
  localparam int unsigned TrsvDepth = 4;
  localparam int unsigned TrsvPtrW  = $clog2(TrsvDepth);
  // pending count runs 0..TrsvDepth
  localparam int unsigned PendW     = TrsvPtrW + 1;
  localparam int unsigned CntW      = 16;
  localparam int unsigned XferW     = 4;

  // transfer sizes in bytes
  localparam logic [XferW-1:0] XferCapB  = 4'd8;
  localparam logic [XferW-1:0] XferWordB = 4'd4;
  localparam logic [XferW-1:0] XferHalfB = 4'd2;
  localparam logic [XferW-1:0] XferByteB = 4'd1;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // same encoding as the core's lsu_type
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  typedef enum logic [3:0] {
    ACC_NULL,
    CAP_RD,
    CAP_WR,
    BYTE_RD,
    BYTE_WR,
    HW_RD_ALIGNED,
    HW_RD_UNALIGNED,
    HW_WR_ALIGNED,
    HW_WR_UNALIGNED,
    WORD_RD_ALIGNED,
    WORD_RD_UNALIGNED,
    WORD_WR_ALIGNED,
    WORD_WR_UNALIGNED
  } lsu_acc_e;

  localparam int unsigned NumAccClass = 13;

  typedef enum logic [1:0] {
    ROOM_OVER  = 2'd0,
    ROOM_EXACT = 2'd1,
    ROOM_SHORT = 2'd2
  } room_chk_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                is_cap;
    logic                we;
    lsu_type_e           lsu_type;
    logic [AddrW-1:0]    addr;
    logic [CapTopW-1:0]  cap_top;
  } lsu_acc_t;

  typedef struct packed {
    lsu_acc_e            acc_class;
    logic [XferW-1:0]    xfer_size;
    room_chk_e           room_chk;
  } lsu_acc_res_t;

  // classifier result for an all-zero access (aligned word read, no room)
  localparam lsu_acc_res_t AccResRst = '{
    acc_class: WORD_RD_ALIGNED,
    xfer_size: XferWordB,
    room_chk:  ROOM_SHORT
  };

endpackage
